//--- sources.f
hdl/lsu_pkg.sv
hdl/isa_pkg.sv
hdl/lsu_ifs.sv
hdl/ls_buffer.sv
hdl/data_memory_unit.sv
hdl/ls_top.sv
dv/tb_clock.sv
dv/ls_sva.sv
dv/ls_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= ls_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ls_tb.sv
/*
 * Directed testbench for the load/store unit top level.
 * Drives issue and bus inputs on the falling edge, samples results there,
 * and keeps a scoreboard of the expected data memory.
 */
`timescale 1ns/1ps
`default_nettype none

module ls_tb
    import lsu_pkg::*;
    import isa_pkg::*;
();
    localparam int ADDR_W = 8;
    localparam int DEPTH = 8;
    // five tests at up to 300 cycles each, plus margin
    localparam int MAX_CYCLES = 5 * 300 + 500;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    logic       flush;
    logic       full;
    logic       load_valid;
    logic       store_done;
    rob_tag_t   issue_tag;
    rob_tag_t   src1_tag;
    rob_tag_t   src2_tag;
    rob_tag_t   rob_head_tag;
    rob_tag_t   load_tag;
    rob_tag_t   store_tag;
    reg_idx_t   issue_rd;
    reg_idx_t   load_rd;
    ls_opcode_t issue_opcode;
    word_t      src1_val;
    word_t      src2_val;
    word_t      imm;
    word_t      load_data;
    rob_tag_t   cdb_tag [CDB_PORTS];
    word_t      cdb_val [CDB_PORTS];

    int       cycles;
    int       errors;
    int       checks;
    int       tests_run;
    int       tests_failed;
    int       test_err0;
    string    test_name;
    word_t    lcg_state;
    word_t    exp_mem [1 << ADDR_W];
    // completion tags in arrival order, loads and stores together
    rob_tag_t done_q [$];
    rob_tag_t ld_tag_q [$];
    reg_idx_t ld_rd_q [$];
    word_t    ld_data_q [$];

    tb_clock u_clk (.clk(clk), .rst(rst));

    ls_top dut (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_tag(issue_tag),
        .issue_rd(issue_rd), .issue_opcode(issue_opcode),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .src1_val(src1_val), .src2_val(src2_val),
        .imm(imm), .rob_head_tag(rob_head_tag), .flush(flush),
        .cdb_tag_0(cdb_tag[0]), .cdb_tag_1(cdb_tag[1]),
        .cdb_tag_2(cdb_tag[2]), .cdb_tag_3(cdb_tag[3]),
        .cdb_val_0(cdb_val[0]), .cdb_val_1(cdb_val[1]),
        .cdb_val_2(cdb_val[2]), .cdb_val_3(cdb_val[3]),
        .full(full), .load_valid(load_valid), .load_tag(load_tag), .load_rd(load_rd),
        .load_data(load_data), .store_done(store_done), .store_tag(store_tag)
    );

    bind ls_buffer ls_sva #(.DEPTH_BITS(DEPTH_BITS)) u_sva (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .full        (full),
        .head_pending(busy[head] && (e_q1[head] != '0 || e_q2[head] != '0)),
        .req_valid   (req.valid),
        .req_opcode  (req.opcode),
        .req_tag     (req.tag),
        .rob_head_tag(rob_head_tag)
    );

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word address is the low ADDR_W bits of base plus offset
    function automatic logic [ADDR_W-1:0] word_addr(input word_t base, input word_t ofs);
        word_t sum;
        sum = base + ofs;
        return sum[ADDR_W-1:0];
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one clock, results sampled at the falling edge
    task automatic tick();
        @(negedge clk);
        cycles++;
        if (store_done) begin
            done_q.push_back(store_tag);
        end
        if (load_valid) begin
            done_q.push_back(load_tag);
            ld_tag_q.push_back(load_tag);
            ld_rd_q.push_back(load_rd);
            ld_data_q.push_back(load_data);
        end
        if (cycles > MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic drive_issue(input ls_opcode_t op, input rob_tag_t tag, input reg_idx_t rd,
                               input rob_tag_t t1, input word_t v1, input rob_tag_t t2,
                               input word_t v2, input word_t ofs);
        issue_opcode = op;
        issue_tag    = tag;
        issue_rd     = rd;
        src1_tag     = t1;
        src1_val     = v1;
        src2_tag     = t2;
        src2_val     = v2;
        imm          = ofs;
        issue_valid  = 1'b1;
    endtask

    // hold the instruction until an edge with full low takes it
    task automatic accept();
        while (full) begin
            tick();
        end
        tick();
        issue_valid = 1'b0;
    endtask

    task automatic issue(input ls_opcode_t op, input rob_tag_t tag, input reg_idx_t rd,
                         input rob_tag_t t1, input word_t v1, input rob_tag_t t2,
                         input word_t v2, input word_t ofs);
        drive_issue(op, tag, rd, t1, v1, t2, v2, ofs);
        accept();
    endtask

    task automatic bcast(input int port, input rob_tag_t tag, input word_t val);
        cdb_tag[port] = tag;
        cdb_val[port] = val;
        tick();
        cdb_tag[port] = '0;
    endtask

    task automatic wait_done(input int n);
        int waited;
        waited = 0;
        while (done_q.size() < n && waited < 100) begin
            tick();
            waited++;
        end
        if (done_q.size() < n) begin
            errors++;
            $display("only %0d of %0d results arrived in %s", done_q.size(), n, test_name);
        end
    endtask

    task automatic check_load(input int idx, input rob_tag_t tag, input reg_idx_t rd,
                              input word_t data);
        check_tag("load_tag", ld_tag_q[idx], tag);
        check_reg("load_rd", ld_rd_q[idx], rd);
        check_word("load_data", ld_data_q[idx], data);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        done_q.delete();
        ld_tag_q.delete();
        ld_rd_q.delete();
        ld_data_q.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_err0);
        end
    endtask

    task automatic test_store_load();
        word_t base;
        word_t ofs;
        word_t data;
        begin_test("store_load");
        base = lcg_next();
        ofs  = lcg_next() & 32'hff;
        data = lcg_next();
        rob_head_tag = 5'd1;
        issue(OP_SW, 5'd1, 5'd0, 5'd0, base, 5'd0, data, ofs);
        issue(OP_LW, 5'd2, 5'd7, 5'd0, base, 5'd0, 32'd0, ofs);
        exp_mem[word_addr(base, ofs)] = data;
        wait_done(2);
        check_tag("store_tag", done_q[0], 5'd1);
        check_load(0, 5'd2, 5'd7, data);
        rob_head_tag = '0;
        end_test();
    endtask

    task automatic test_pending_base();
        word_t base;
        word_t ofs;
        word_t data;
        begin_test("pending_base");
        for (int p = 0; p < CDB_PORTS; p++) begin
            base = lcg_next();
            ofs  = lcg_next() & 32'hff;
            data = lcg_next();
            rob_head_tag = 5'd3;
            issue(OP_SW, 5'd3, 5'd0, 5'd0, base, 5'd0, data, ofs);
            exp_mem[word_addr(base, ofs)] = data;
            wait_done(1);
            done_q.delete();
            // base value still to come from the bus
            issue(OP_LW, 5'(8 + p), 5'(p + 1), 5'(20 + p), ~base, 5'd0, 32'd0, ofs);
            repeat (6) tick();
            check_bit("load_valid", ld_tag_q.size() != 0, 1'b0);
            bcast(p, 5'(20 + p), base);
            wait_done(1);
            check_load(0, 5'(8 + p), 5'(p + 1), data);
            done_q.delete();
            ld_tag_q.delete();
            ld_rd_q.delete();
            ld_data_q.delete();
        end
        rob_head_tag = '0;
        end_test();
    endtask

    task automatic test_store_order();
        word_t base;
        word_t ofs;
        word_t data;
        begin_test("store_order");
        base = lcg_next();
        ofs  = lcg_next() & 32'hff;
        data = lcg_next();
        rob_head_tag = '0;
        issue(OP_SW, 5'd10, 5'd0, 5'd0, base, 5'd0, data, ofs);
        issue(OP_LW, 5'd11, 5'd9, 5'd0, base, 5'd0, 32'd0, ofs);
        repeat (8) tick();
        check_bit("store_done", done_q.size() != 0, 1'b0);
        rob_head_tag = 5'd10;
        exp_mem[word_addr(base, ofs)] = data;
        wait_done(2);
        check_tag("first completion", done_q[0], 5'd10);
        check_tag("second completion", done_q[1], 5'd11);
        check_load(0, 5'd11, 5'd9, data);
        rob_head_tag = '0;
        end_test();
    endtask

    task automatic test_full();
        word_t bases [DEPTH + 1];
        word_t ofs;
        begin_test("full");
        ofs = lcg_next() & 32'hff;
        for (int i = 0; i < DEPTH; i++) begin
            bases[i] = lcg_next();
            issue(OP_LW, 5'(12 + i), 5'(i), 5'(1 + i), 32'd0, 5'd0, 32'd0, ofs);
        end
        check_bit("full", full, 1'b1);
        bases[DEPTH] = lcg_next();
        drive_issue(OP_LW, 5'(12 + DEPTH), 5'(DEPTH), 5'(1 + DEPTH), 32'd0, 5'd0, 32'd0, ofs);
        repeat (4) tick();
        check_bit("full", full, 1'b1);
        // two bus cycles cover all eight pending bases
        for (int c = 0; c < 2; c++) begin
            for (int p = 0; p < CDB_PORTS; p++) begin
                cdb_tag[p] = 5'(1 + 4 * c + p);
                cdb_val[p] = bases[4 * c + p];
            end
            tick();
        end
        for (int p = 0; p < CDB_PORTS; p++) begin
            cdb_tag[p] = '0;
        end
        accept();
        bcast(0, 5'(1 + DEPTH), bases[DEPTH]);
        wait_done(DEPTH + 1);
        for (int i = 0; i <= DEPTH; i++) begin
            check_load(i, 5'(12 + i), 5'(i), exp_mem[word_addr(bases[i], ofs)]);
        end
        end_test();
    endtask

    task automatic test_flush();
        word_t base;
        word_t ofs;
        word_t data;
        begin_test("flush");
        base = lcg_next();
        ofs  = lcg_next() & 32'hff;
        data = lcg_next();
        rob_head_tag = '0;
        issue(OP_SW, 5'd21, 5'd0, 5'd0, base, 5'd0, data, ofs);
        issue(OP_LW, 5'd22, 5'd3, 5'd30, 32'd0, 5'd0, 32'd0, ofs);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        // operands that would have released both entries
        rob_head_tag = 5'd21;
        bcast(0, 5'd30, base);
        repeat (8) tick();
        check_bit("completion after flush", done_q.size() != 0, 1'b0);
        rob_head_tag = '0;
        issue(OP_LW, 5'd23, 5'd4, 5'd0, base, 5'd0, 32'd0, ofs);
        wait_done(1);
        check_load(0, 5'd23, 5'd4, exp_mem[word_addr(base, ofs)]);
        end_test();
    endtask

    initial begin
        issue_valid  = 1'b0;
        flush        = 1'b0;
        issue_tag    = '0;
        issue_rd     = '0;
        issue_opcode = '0;
        src1_tag     = '0;
        src2_tag     = '0;
        src1_val     = '0;
        src2_val     = '0;
        imm          = '0;
        rob_head_tag = '0;
        for (int p = 0; p < CDB_PORTS; p++) begin
            cdb_tag[p] = '0;
            cdb_val[p] = '0;
        end
        lcg_state = 32'd56;
        // memory comes out of reset cleared
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            exp_mem[a] = '0;
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        test_store_load();
        test_pending_base();
        test_store_order();
        test_full();
        test_flush();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : ls_tb

`default_nettype wire

//--- dv/ls_sva.sv
/*
 * Concurrent checks on the load/store buffer, bound into ls_buffer
 * from the testbench.
 */
`timescale 1ns/1ps
`default_nettype none

module ls_sva
    import lsu_pkg::*;
    import isa_pkg::*;
#(
    parameter int DEPTH_BITS = 3
) (
    input wire                          clk,
    input wire                          rst,
    input wire [(1 << DEPTH_BITS)-1:0]  busy,
    input wire                          full,
    input wire                          head_pending,
    input wire                          req_valid,
    input wire ls_opcode_t              req_opcode,
    input wire rob_tag_t                req_tag,
    input wire rob_tag_t                rob_head_tag
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    // occupancy taken from the busy bits, not from the counter behind full
    full_only_when_all_taken: assert property (
        @(posedge clk) disable iff (rst) ($countones(busy) < DEPTH) |-> !full
    ) else $error("full high with only %0d busy entries", $countones(busy));

    // strobe follows the decision cycle by one
    no_dispatch_with_pending: assert property (
        @(posedge clk) disable iff (rst) head_pending |=> !req_valid
    ) else $error("request strobe after a head with a pending operand");

    store_at_rob_head: assert property (
        @(posedge clk) disable iff (rst)
        (req_valid && req_opcode == OP_SW) |-> (req_tag == $past(rob_head_tag))
    ) else $error("store tag 0x%h left while not at the reorder buffer head", req_tag);

endmodule : ls_sva

`default_nettype wire

//--- dv/tb_clock.sv
/*
 * Clock and reset source for the load/store unit testbench.
 * Reset is held high for the first RST_CYCLES rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_NS    = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

//--- hdl/ls_top.sv
/*
 * Top level of the load/store unit.
 * Plain ports for issue, bus and results; the bus and the request path
 * run over interfaces between the buffer and the memory unit.
 */
`timescale 1ns/1ps
`default_nettype none

module ls_top
    import lsu_pkg::*;
    import isa_pkg::*;
#(
    parameter int DEPTH_BITS = 3,
    parameter int ADDR_W     = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             issue_valid,
    input  wire rob_tag_t   issue_tag,
    input  wire reg_idx_t   issue_rd,
    input  wire ls_opcode_t issue_opcode,
    input  wire rob_tag_t   src1_tag,
    input  wire rob_tag_t   src2_tag,
    input  wire word_t      src1_val,
    input  wire word_t      src2_val,
    input  wire word_t      imm,
    input  wire rob_tag_t   rob_head_tag,
    input  wire             flush,
    input  wire rob_tag_t   cdb_tag_0,
    input  wire rob_tag_t   cdb_tag_1,
    input  wire rob_tag_t   cdb_tag_2,
    input  wire rob_tag_t   cdb_tag_3,
    input  wire word_t      cdb_val_0,
    input  wire word_t      cdb_val_1,
    input  wire word_t      cdb_val_2,
    input  wire word_t      cdb_val_3,
    output logic            full,
    output logic            load_valid,
    output rob_tag_t        load_tag,
    output reg_idx_t        load_rd,
    output word_t           load_data,
    output logic            store_done,
    output rob_tag_t        store_tag
);

    cdb_if                      cdb ();
    mem_req_if #(.ADDR_W(ADDR_W)) req ();

    // bus pairs in port order, pair 0 has priority
    assign cdb.tag[0] = cdb_tag_0;
    assign cdb.tag[1] = cdb_tag_1;
    assign cdb.tag[2] = cdb_tag_2;
    assign cdb.tag[3] = cdb_tag_3;
    assign cdb.val[0] = cdb_val_0;
    assign cdb.val[1] = cdb_val_1;
    assign cdb.val[2] = cdb_val_2;
    assign cdb.val[3] = cdb_val_3;

    ls_buffer #(
        .DEPTH_BITS(DEPTH_BITS),
        .ADDR_W    (ADDR_W)
    ) u_buffer (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_rd    (issue_rd),
        .issue_opcode(issue_opcode),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_val    (src1_val),
        .src2_val    (src2_val),
        .imm         (imm),
        .rob_head_tag(rob_head_tag),
        .full        (full),
        .cdb         (cdb.snoop),
        .req         (req.issuer)
    );

    data_memory_unit #(
        .ADDR_W(ADDR_W)
    ) u_dmem (
        .clk       (clk),
        .rst       (rst),
        .req       (req.executor),
        .load_valid(load_valid),
        .load_tag  (load_tag),
        .load_rd   (load_rd),
        .load_data (load_data),
        .store_done(store_done),
        .store_tag (store_tag)
    );

endmodule : ls_top

`default_nettype wire

//--- hdl/data_memory_unit.sv
/*
 * Word-addressed data memory behind the load/store buffer.
 * Executes one request per cycle and registers the load result or the
 * store completion one cycle after the request strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module data_memory_unit
    import lsu_pkg::*;
    import isa_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  wire        clk,
    input  wire        rst,
    mem_req_if.executor req,
    output logic       load_valid,
    output rob_tag_t   load_tag,
    output reg_idx_t   load_rd,
    output word_t      load_data,
    output logic       store_done,
    output rob_tag_t   store_tag
);

    localparam int WORDS = 1 << ADDR_W;

    word_t mem [WORDS];

    logic is_load;
    logic is_store;

    assign is_load  = req.valid && req.opcode == OP_LW;
    assign is_store = req.valid && req.opcode == OP_SW;

    // contents start from zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (is_store) begin
            mem[req.addr] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
            store_done <= 1'b0;
        end else begin
            load_valid <= is_load;
            store_done <= is_store;
        end
    end

    // result payload, read before any write in the same cycle
    always_ff @(posedge clk) begin
        if (is_load) begin
            load_tag  <= req.tag;
            load_rd   <= req.rd;
            load_data <= mem[req.addr];
        end
        if (is_store) begin
            store_tag <= req.tag;
        end
    end

endmodule : data_memory_unit

`default_nettype wire

//--- hdl/ls_buffer.sv
/*
 * Circular load/store buffer. Entries snoop the common data bus for their
 * operands, recompute the address when the base arrives and leave in program
 * order from the head. Stores wait for the reorder buffer head.
 */
`timescale 1ns/1ps
`default_nettype none

module ls_buffer
    import lsu_pkg::*;
    import isa_pkg::*;
#(
    parameter int DEPTH_BITS = 3,
    parameter int ADDR_W     = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             flush,
    input  wire             issue_valid,
    input  wire rob_tag_t   issue_tag,
    input  wire reg_idx_t   issue_rd,
    input  wire ls_opcode_t issue_opcode,
    input  wire rob_tag_t   src1_tag,
    input  wire rob_tag_t   src2_tag,
    input  wire word_t      src1_val,
    input  wire word_t      src2_val,
    input  wire word_t      imm,
    input  wire rob_tag_t   rob_head_tag,
    output logic            full,
    cdb_if.snoop            cdb,
    mem_req_if.issuer       req
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    // entry state
    logic [DEPTH-1:0]  busy;
    ls_opcode_t        e_opcode [DEPTH];
    reg_idx_t          e_rd     [DEPTH];
    rob_tag_t          e_tag    [DEPTH];
    rob_tag_t          e_q1     [DEPTH];
    rob_tag_t          e_q2     [DEPTH];
    word_t             e_v2     [DEPTH];
    word_t             e_imm    [DEPTH];
    logic [ADDR_W-1:0] e_addr   [DEPTH];

    logic [DEPTH_BITS-1:0] head;
    logic [DEPTH_BITS-1:0] tail;
    logic [DEPTH_BITS:0]   count;

    logic  s1_hit [DEPTH];
    logic  s2_hit [DEPTH];
    word_t s1_val [DEPTH];
    word_t s2_val [DEPTH];
    logic  i1_hit;
    logic  i2_hit;
    word_t i1_val;
    word_t i2_val;
    word_t i_base;
    logic  issue_acc;
    logic  head_ready;
    logic  dispatch;

    // scan from the top so that pair 0 has the last word on a tie
    function automatic logic bus_hit(input rob_tag_t t, output word_t v);
        logic hit;
        hit = 1'b0;
        v   = '0;
        for (int p = CDB_PORTS - 1; p >= 0; p--) begin
            if (t != '0 && cdb.tag[p] == t) begin
                hit = 1'b1;
                v   = cdb.val[p];
            end
        end
        return hit;
    endfunction

    // word address is the low bits of base + imm
    function automatic logic [ADDR_W-1:0] calc_addr(input word_t base, input word_t ofs);
        addr_t sum;
        sum = base + ofs;
        return sum[ADDR_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            s1_hit[i] = bus_hit(e_q1[i], s1_val[i]);
            s2_hit[i] = bus_hit(e_q2[i], s2_val[i]);
        end
        // operands broadcast in the issue cycle itself
        i1_hit = bus_hit(src1_tag, i1_val);
        i2_hit = bus_hit(src2_tag, i2_val);
    end

    assign i_base    = i1_hit ? i1_val : src1_val;
    assign full      = (count == (DEPTH_BITS + 1)'(DEPTH));
    assign issue_acc = issue_valid && !full;

    // stores only leave when they are the oldest in the reorder buffer
    assign head_ready = busy[head] && e_q1[head] == '0 && e_q2[head] == '0 &&
                        (e_opcode[head] != OP_SW || e_tag[head] == rob_head_tag);
    assign dispatch   = head_ready && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue_acc) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (dispatch) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + (DEPTH_BITS + 1)'(issue_acc) - (DEPTH_BITS + 1)'(dispatch);
        end
    end

    // entry payload, qualified by busy
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (issue_acc && tail == DEPTH_BITS'(i)) begin
                e_opcode[i] <= issue_opcode;
                e_rd[i]     <= issue_rd;
                e_tag[i]    <= issue_tag;
                e_imm[i]    <= imm;
                e_q1[i]     <= i1_hit ? '0 : src1_tag;
                e_q2[i]     <= i2_hit ? '0 : src2_tag;
                e_v2[i]     <= i2_hit ? i2_val : src2_val;
                e_addr[i]   <= calc_addr(i_base, imm);
            end else if (busy[i]) begin
                if (s1_hit[i]) begin
                    e_q1[i]   <= '0;
                    e_addr[i] <= calc_addr(s1_val[i], e_imm[i]);
                end
                if (s2_hit[i]) begin
                    e_q2[i] <= '0;
                    e_v2[i] <= s2_val[i];
                end
            end
        end
    end

    // registered request strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= dispatch;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            req.opcode <= e_opcode[head];
            req.tag    <= e_tag[head];
            req.rd     <= e_rd[head];
            req.addr   <= e_addr[head];
            // store data comes from the second operand
            req.wdata  <= e_v2[head];
        end
    end

endmodule : ls_buffer

`default_nettype wire

//--- hdl/lsu_ifs.sv
/*
 * Interfaces between the load/store buffer, the memory unit and the top level.
 * cdb_if carries the bus broadcasts, mem_req_if the dispatched requests.
 */
`timescale 1ns/1ps
`default_nettype none

// four tag/value pairs, a pair is live when its tag is non-zero
interface cdb_if
    import lsu_pkg::*;
();
    rob_tag_t tag [CDB_PORTS];
    word_t    val [CDB_PORTS];

    modport source (output tag, output val);
    modport snoop  (input tag, input val);
endinterface : cdb_if

// one request per cycle at most, valid is a single-cycle strobe
interface mem_req_if
    import lsu_pkg::*;
    import isa_pkg::*;
#(
    parameter int ADDR_W = 8
) ();
    logic              valid;
    ls_opcode_t        opcode;
    rob_tag_t          tag;
    reg_idx_t          rd;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;

    modport issuer   (output valid, output opcode, output tag, output rd,
                      output addr, output wdata);
    modport executor (input valid, input opcode, input tag, input rd,
                      input addr, input wdata);
endinterface : mem_req_if

`default_nettype wire

//--- hdl/isa_pkg.sv
/*
 * Opcode encoding of the load and store instructions handled here.
 * The field is {spare, funct3, major opcode} as used by the issue logic.
 */
`default_nettype none

package isa_pkg;

    typedef logic [11:0] ls_opcode_t;

    // RV32 major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 for a full word access
    localparam logic [2:0] F3_WORD = 3'b010;

    // two spare bits stay zero
    localparam ls_opcode_t OP_LW = {2'b00, F3_WORD, OPC_LOAD};
    localparam ls_opcode_t OP_SW = {2'b00, F3_WORD, OPC_STORE};

endpackage : isa_pkg

`default_nettype wire

//--- hdl/lsu_pkg.sv
/*
 * Datapath widths and shared types for the load/store unit.
 * Imported by the buffer, the memory unit, the interfaces and the top level.
 */
`default_nettype none

package lsu_pkg;

    // reorder-buffer tag, zero means the value is already present
    typedef logic [4:0] rob_tag_t;

    // architectural data word
    typedef logic [31:0] word_t;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // full-width effective address before it is cut to the memory size
    typedef logic [31:0] addr_t;

    // number of common data bus ports that every entry snoops
    localparam int CDB_PORTS = 4;

endpackage : lsu_pkg

`default_nettype wire
